// ==== src.f ====
hdl/link_pkg.sv
hdl/cspi_rx.sv
hdl/line_tx.sv
hdl/line_rx.sv
hdl/cmd_link_top.sv
tests/cmd_link_sva.sv
tests/cmd_link_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = cmd_link_tb
FILELIST = src.f

SRCS = $(shell cat $(FILELIST))
BIN  = obj_dir/V$(TOP)
LOG  = sim.log

.PHONY: all run clean

all: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "Testbench failed" $(LOG) || ! grep -q "Testbench passed" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// ==== tests/cmd_link_tb.sv ====
`default_nettype none

module cmd_link_tb;
  localparam int         BIT_DIV   = 8;
  localparam logic [7:0] DEV_ID    = 8'h12;
  localparam int         FRAME_CYC = 60 * BIT_DIV;

  logic        clk_sys;
  logic        rst_n;
  logic        spi_csn;
  logic        spi_sck;
  logic        spi_mosi;
  logic        rx_line = 1'b1;
  logic [3:0]  rd_addr;
  logic        tx_line;
  logic        tx_de;
  logic        tx_busy;
  logic [7:0]  rd_data;
  logic [15:0] ok_cnt;
  logic [15:0] err_cnt;
  logic [7:0]  last_mod;

  // fault injection inverts one bit slot of the frame
  logic        fault_en;
  int          fault_slot;
  int          frame_cyc    = 0;
  int          frame_starts = 0;

  // reference model of the slave
  logic [7:0]  model_regs [16];
  logic [15:0] exp_ok;
  logic [15:0] exp_err;
  logic [7:0]  exp_mod;

  int          n_checks;
  int          n_errors;
  int          start_errs;
  int          starts0;
  int          n_bad;
  logic [7:0]  mod;
  logic [7:0]  addr;
  logic [7:0]  addr2;
  logic [7:0]  data;
  logic [7:0]  data2;
  logic [7:0]  dev;
  logic [7:0]  rd;

  cmd_link_top #(
    .BIT_DIV (BIT_DIV),
    .DEV_ID  (DEV_ID)
  ) i_dut (
    .clk_sys  (clk_sys),
    .rst_n    (rst_n),
    .spi_csn  (spi_csn),
    .spi_sck  (spi_sck),
    .spi_mosi (spi_mosi),
    .rx_line  (rx_line),
    .tx_line  (tx_line),
    .tx_de    (tx_de),
    .tx_busy  (tx_busy),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data),
    .ok_cnt   (ok_cnt),
    .err_cnt  (err_cnt),
    .last_mod (last_mod)
  );

  initial begin
    clk_sys = 1'b0;
    forever #4 clk_sys = ~clk_sys;
  end

  // loopback idles high while the line driver is off
  always @(negedge clk_sys) begin
    if (tx_de) begin
      if (frame_cyc == 0) begin
        frame_starts <= frame_starts + 1;
      end
      rx_line   <= tx_line ^ (fault_en && (frame_cyc / BIT_DIV) == fault_slot);
      frame_cyc <= frame_cyc + 1;
    end else begin
      rx_line   <= 1'b1;
      frame_cyc <= 0;
    end
  end

  task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("FAIL t=%0t: %s got 0x%0h, expected 0x%0h", $time, what, got, exp);
    end
  endtask

  // mode 0 with a half period of 3 clocks
  task automatic spi_send(input logic [31:0] word, input int nbits);
    repeat (2) @(negedge clk_sys);
    spi_csn = 1'b0;
    for (int i = 0; i < nbits; i++) begin
      spi_mosi = (i < 32) ? word[31-i] : 1'b0;
      repeat (3) @(negedge clk_sys);
      spi_sck = 1'b1;
      repeat (3) @(negedge clk_sys);
      spi_sck = 1'b0;
    end
    repeat (3) @(negedge clk_sys);
    spi_csn  = 1'b1;
    spi_mosi = 1'b0;
  endtask

  task automatic wait_busy(input logic level, input int limit, input string what);
    int n;
    n = 0;
    while (tx_busy !== level && n < limit) begin
      @(negedge clk_sys);
      n++;
    end
    if (tx_busy !== level) begin
      n_errors++;
      $display("timeout at %0t while waiting for %s", $time, what);
    end
  endtask

  task automatic run_cmd(input logic [31:0] word);
    spi_send(word, 32);
    wait_busy(1'b1, 16, "tx_busy to rise");
    wait_busy(1'b0, FRAME_CYC + 16, "end of frame");
    repeat (2 * BIT_DIV) @(negedge clk_sys);
  endtask

  task automatic read_reg(input logic [3:0] a, output logic [7:0] val);
    @(negedge clk_sys);
    rd_addr = a;
    @(negedge clk_sys);
    val = rd_data;
  endtask

  task automatic check_counters();
    check_val("ok_cnt", ok_cnt, exp_ok);
    check_val("err_cnt", err_cnt, exp_err);
  endtask

  task automatic check_all_regs();
    logic [7:0] val;
    for (int a = 0; a < 16; a++) begin
      read_reg(4'(a), val);
      check_val($sformatf("register %0d", a), val, model_regs[a]);
    end
  endtask

  task automatic test_done(input string name, input int errs0);
    if (n_errors == errs0) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, n_errors - errs0);
    end
  endtask

  initial begin
    void'($urandom(32'hddff9b96));
    rst_n    = 1'b0;
    spi_csn  = 1'b1;
    spi_sck  = 1'b0;
    spi_mosi = 1'b0;
    rd_addr  = 4'h0;
    fault_en = 1'b0;
    fault_slot = 0;
    n_checks = 0;
    n_errors = 0;
    exp_ok   = '0;
    exp_err  = '0;
    exp_mod  = '0;
    for (int a = 0; a < 16; a++) begin
      model_regs[a] = 8'h00;
    end
    repeat (4) @(negedge clk_sys);
    rst_n = 1'b1;
    repeat (4) @(negedge clk_sys);

    start_errs = n_errors;
    for (int k = 0; k < 40; k++) begin
      mod  = 8'($urandom);
      addr = 8'($urandom);
      data = 8'($urandom);
      run_cmd({DEV_ID, mod, addr, data});
      model_regs[addr[3:0]] = data;
      exp_ok  = exp_ok + 16'd1;
      exp_mod = mod;
      read_reg(addr[3:0], rd);
      check_val("rd_data", rd, data);
      check_val("ok_cnt", ok_cnt, exp_ok);
      check_val("last_mod", last_mod, exp_mod);
    end
    test_done("random_writes", start_errs);

    start_errs = n_errors;
    for (int k = 0; k < 8; k++) begin
      dev = 8'($urandom);
      if (dev == DEV_ID) begin
        dev = dev ^ 8'h01;
      end
      addr = 8'($urandom);
      data = ~model_regs[addr[3:0]];
      starts0 = frame_starts;
      run_cmd({dev, 8'($urandom), addr, data});
      check_val("frames on the line", frame_starts, starts0 + 1);
      check_counters();
      check_all_regs();
    end
    test_done("other_devices", start_errs);

    // invert one data bit of bytes 1 to 5 but no start or stop bit
    start_errs = n_errors;
    for (int k = 0; k < 8; k++) begin
      addr = 8'($urandom);
      data = ~model_regs[addr[3:0]];
      fault_slot = (1 + $urandom % 5) * 10 + 1 + $urandom % 8;
      fault_en   = 1'b1;
      run_cmd({DEV_ID, 8'($urandom), addr, data});
      fault_en = 1'b0;
      exp_err  = exp_err + 16'd1;
      check_counters();
      read_reg(addr[3:0], rd);
      check_val("register after bad frame", rd, model_regs[addr[3:0]]);
    end
    test_done("corrupted_frames", start_errs);

    start_errs = n_errors;
    for (int k = 0; k < 2; k++) begin
      starts0 = frame_starts;
      spi_send({DEV_ID, 8'($urandom), 8'($urandom), 8'($urandom)}, (k == 0) ? 31 : 33);
      n_bad = 0;
      repeat (80 * BIT_DIV) begin
        @(negedge clk_sys);
        if (tx_de) begin
          n_bad++;
        end
      end
      check_val("cycles with tx_de high", n_bad, 0);
      check_val("frames on the line", frame_starts, starts0);
      check_counters();
    end
    test_done("bad_spi", start_errs);

    start_errs = n_errors;
    for (int k = 0; k < 4; k++) begin
      mod   = 8'($urandom);
      addr  = 8'($urandom);
      addr2 = {addr[7:4], addr[3:0] + 4'd1};
      data  = 8'($urandom);
      data2 = ~model_regs[addr2[3:0]];
      spi_send({DEV_ID, mod, addr, data}, 32);
      wait_busy(1'b1, 16, "tx_busy to rise");
      spi_send({DEV_ID, 8'h00, addr2, data2}, 32);
      check_val("tx_busy during second command", tx_busy, 1);
      wait_busy(1'b0, FRAME_CYC + 16, "end of frame");
      repeat (2 * BIT_DIV) @(negedge clk_sys);
      check_val("tx_busy after dropped command", tx_busy, 0);
      model_regs[addr[3:0]] = data;
      exp_ok  = exp_ok + 16'd1;
      exp_mod = mod;
      read_reg(addr[3:0], rd);
      check_val("first command register", rd, data);
      read_reg(addr2[3:0], rd);
      check_val("dropped command register", rd, model_regs[addr2[3:0]]);
      check_counters();
      check_val("last_mod", last_mod, exp_mod);
    end
    test_done("busy_drop", start_errs);

    start_errs = n_errors;
    check_all_regs();
    check_counters();
    test_done("readback", start_errs);

    $display("checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tests/cmd_link_sva.sv ====
`default_nettype none

module cmd_link_sva (
  input logic        clk_sys,
  input logic        rst_n,
  input logic        tx_line,
  input logic        tx_de,
  input logic        tx_busy,
  input logic [15:0] ok_cnt,
  input logic [15:0] err_cnt,
  input logic        cmd_vld
);

  // line idles high whenever the driver is off
  a_idle_high: assert property (@(posedge clk_sys) disable iff (!rst_n) !tx_de |-> tx_line)
    else $error("tx_line low while tx_de is low");

  a_de_busy: assert property (@(posedge clk_sys) disable iff (!rst_n) tx_de |-> tx_busy)
    else $error("tx_de high without tx_busy");

  // counters step by one and never together
  a_ok_step: assert property (@(posedge clk_sys) disable iff (!rst_n)
    (ok_cnt != $past(ok_cnt)) |-> (ok_cnt == $past(ok_cnt) + 16'd1))
    else $error("ok_cnt jumped");

  a_err_step: assert property (@(posedge clk_sys) disable iff (!rst_n)
    (err_cnt != $past(err_cnt)) |-> (err_cnt == $past(err_cnt) + 16'd1))
    else $error("err_cnt jumped");

  a_cnt_excl: assert property (@(posedge clk_sys) disable iff (!rst_n)
    !((ok_cnt != $past(ok_cnt)) && (err_cnt != $past(err_cnt))))
    else $error("ok_cnt and err_cnt changed in the same cycle");

  a_vld_pulse: assert property (@(posedge clk_sys) disable iff (!rst_n) cmd_vld |=> !cmd_vld)
    else $error("cmd_vld longer than one cycle");

endmodule

bind cmd_link_top cmd_link_sva i_sva (
  .clk_sys (clk_sys),
  .rst_n   (rst_n),
  .tx_line (tx_line),
  .tx_de   (tx_de),
  .tx_busy (tx_busy),
  .ok_cnt  (ok_cnt),
  .err_cnt (err_cnt),
  .cmd_vld (cmd_vld)
);

`default_nettype wire

// ==== hdl/cmd_link_top.sv ====
`default_nettype none

module cmd_link_top #(
  parameter int         BIT_DIV = 8,
  parameter logic [7:0] DEV_ID  = 8'h12
) (
  //clk rst
  input  logic        clk_sys,
  input  logic        rst_n,
  //control spi
  input  logic        spi_csn,
  input  logic        spi_sck,
  input  logic        spi_mosi,
  //485 line
  input  logic        rx_line,
  output logic        tx_line,
  output logic        tx_de,
  output logic        tx_busy,
  //slave register readback
  input  logic [3:0]  rd_addr,
  output logic [7:0]  rd_data,
  output logic [15:0] ok_cnt,
  output logic [15:0] err_cnt,
  output logic [7:0]  last_mod
);
  import link_pkg::*;

  logic [CMD_W-1:0] cmd_word;
  logic             cmd_vld;

  cspi_rx u_cspi_rx (
    .clk_sys  (clk_sys),
    .rst_n    (rst_n),
    .spi_csn  (spi_csn),
    .spi_sck  (spi_sck),
    .spi_mosi (spi_mosi),
    .cmd_word (cmd_word),
    .cmd_vld  (cmd_vld)
  );

  // master side
  line_tx #(
    .BIT_DIV (BIT_DIV)
  ) u_line_tx (
    .clk_sys  (clk_sys),
    .rst_n    (rst_n),
    .cmd_word (cmd_word),
    .cmd_vld  (cmd_vld),
    .tx_line  (tx_line),
    .tx_de    (tx_de),
    .tx_busy  (tx_busy)
  );

  // slave node
  line_rx #(
    .BIT_DIV (BIT_DIV),
    .DEV_ID  (DEV_ID)
  ) u_line_rx (
    .clk_sys  (clk_sys),
    .rst_n    (rst_n),
    .rx_line  (rx_line),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data),
    .ok_cnt   (ok_cnt),
    .err_cnt  (err_cnt),
    .last_mod (last_mod)
  );

endmodule

`default_nettype wire

// ==== hdl/line_rx.sv ====
`default_nettype none

module line_rx #(
  parameter int         BIT_DIV = 8,
  parameter logic [7:0] DEV_ID  = 8'h12
) (
  input  logic        clk_sys,
  input  logic        rst_n,
  input  logic        rx_line,
  input  logic [3:0]  rd_addr,
  output logic [7:0]  rd_data,
  output logic [15:0] ok_cnt,
  output logic [15:0] err_cnt,
  output logic [7:0]  last_mod
);
  import link_pkg::*;

  localparam int DIV_W = $clog2(BIT_DIV);
  // sample point, counted from start-bit detection
  localparam logic [DIV_W-1:0] MID  = DIV_W'((BIT_DIV - 1) / 2);
  localparam logic [DIV_W-1:0] LAST = DIV_W'(BIT_DIV - 1);
  localparam logic [2:0] CSUM_IDX = 3'(FRAME_BYTES - 1);

  logic [2:0]       rx_sync;
  logic             rx_s;
  logic             rx_d;
  rx_state_t        state;
  logic [DIV_W-1:0] div_cnt;
  logic [2:0]       bit_idx;
  logic [2:0]       byte_idx;
  logic [7:0]       shift_q;
  logic [7:0]       frm_q [4];
  logic [7:0]       regs [16];
  logic [7:0]       csum;
  logic             stop_smp;
  logic             frm_ok;
  logic             frm_bad;

  always_ff @(posedge clk_sys or negedge rst_n) begin
    if (!rst_n) begin
      rx_sync <= 3'b111;
    end else begin
      rx_sync <= {rx_sync[1:0], rx_line};
    end
  end

  assign rx_s = rx_sync[1];
  assign rx_d = rx_sync[2];

  always_ff @(posedge clk_sys or negedge rst_n) begin
    if (!rst_n) begin
      state   <= rx_idle;
      div_cnt <= '0;
      bit_idx <= '0;
    end else begin
      div_cnt <= div_cnt + 1'b1;
      case (state)
        rx_idle: begin
          div_cnt <= '0;
          if (rx_d && !rx_s) begin
            state <= rx_start;
          end
        end
        rx_start: begin
          // start bit must still be low at mid-bit, else a glitch
          if (div_cnt == MID) begin
            div_cnt <= '0;
            bit_idx <= '0;
            state   <= rx_s ? rx_idle : rx_data;
          end
        end
        rx_data: begin
          if (div_cnt == LAST) begin
            div_cnt <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state <= rx_stop;
            end
          end
        end
        rx_stop: begin
          if (div_cnt == LAST) begin
            state <= rx_idle;
          end
        end
        default: state <= rx_idle;
      endcase
    end
  end

  assign stop_smp = (state == rx_stop) && (div_cnt == LAST);
  assign csum     = frm_q[0] ^ frm_q[1] ^ frm_q[2] ^ frm_q[3];
  assign frm_ok   = stop_smp && rx_s && byte_idx == CSUM_IDX && shift_q == csum
                    && frm_q[0] == DEV_ID;
  // only bytes inside a frame count as errors
  assign frm_bad  = stop_smp && byte_idx != 3'd0
                    && (!rx_s || (byte_idx == CSUM_IDX && shift_q != csum));

  // payload bytes 1..4 land in the frame buffer
  always_ff @(posedge clk_sys) begin
    if (state == rx_data && div_cnt == LAST) begin
      shift_q <= {rx_s, shift_q[7:1]};
    end
    if (stop_smp && rx_s && byte_idx != 3'd0 && byte_idx != CSUM_IDX) begin
      frm_q[2'(byte_idx - 3'd1)] <= shift_q;
    end
  end

  // hunt for sync at slot 0, any error drops back to the hunt
  always_ff @(posedge clk_sys or negedge rst_n) begin
    if (!rst_n) begin
      byte_idx <= '0;
    end else if (stop_smp) begin
      if (!rx_s || byte_idx == CSUM_IDX) begin
        byte_idx <= '0;
      end else if (byte_idx != 3'd0 || shift_q == SYNC_BYTE) begin
        byte_idx <= byte_idx + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_sys or negedge rst_n) begin
    if (!rst_n) begin
      ok_cnt   <= '0;
      err_cnt  <= '0;
      last_mod <= '0;
      for (int i = 0; i < 16; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (frm_ok) begin
        regs[frm_q[2][3:0]] <= frm_q[3];
        ok_cnt              <= ok_cnt + 1'b1;
        last_mod            <= frm_q[1];
      end
      if (frm_bad) begin
        err_cnt <= err_cnt + 1'b1;
      end
    end
  end

  assign rd_data = regs[rd_addr];

endmodule

`default_nettype wire

// ==== hdl/line_tx.sv ====
`default_nettype none

module line_tx #(
  parameter int BIT_DIV = 8
) (
  input  logic                       clk_sys,
  input  logic                       rst_n,
  input  logic [link_pkg::CMD_W-1:0] cmd_word,
  input  logic                       cmd_vld,
  output logic                       tx_line,
  output logic                       tx_de,
  output logic                       tx_busy
);
  import link_pkg::*;

  localparam int DIV_W = $clog2(BIT_DIV);
  localparam logic [2:0] LAST_BYTE = 3'(FRAME_BYTES - 1);

  tx_state_t        state;
  logic [DIV_W-1:0] div_cnt;
  logic [2:0]       bit_idx;
  logic [2:0]       byte_idx;
  logic [CMD_W-1:0] cmd_q;
  logic [7:0]       csum_q;
  logic [7:0]       cur_byte;
  logic             bit_end;
  logic             accept;

  // no queue, a command during a frame is lost
  assign accept  = cmd_vld && (state == tx_idle);
  assign bit_end = (div_cnt == DIV_W'(BIT_DIV - 1));

  always_ff @(posedge clk_sys) begin
    if (accept) begin
      cmd_q  <= cmd_word;
      csum_q <= cmd_word[31:24] ^ cmd_word[23:16] ^ cmd_word[15:8] ^ cmd_word[7:0];
    end
  end

  // byte on the line for the current frame slot
  always_comb begin
    case (byte_idx)
      3'd0:    cur_byte = SYNC_BYTE;
      3'd1:    cur_byte = cmd_q[31:24];
      3'd2:    cur_byte = cmd_q[23:16];
      3'd3:    cur_byte = cmd_q[15:8];
      3'd4:    cur_byte = cmd_q[7:0];
      default: cur_byte = csum_q;
    endcase
  end

  always_ff @(posedge clk_sys or negedge rst_n) begin
    if (!rst_n) begin
      state    <= tx_idle;
      div_cnt  <= '0;
      bit_idx  <= '0;
      byte_idx <= '0;
    end else begin
      if (state == tx_idle || bit_end) begin
        div_cnt <= '0;
      end else begin
        div_cnt <= div_cnt + 1'b1;
      end

      case (state)
        tx_idle: begin
          if (accept) begin
            state    <= tx_start;
            byte_idx <= '0;
          end
        end
        tx_start: begin
          if (bit_end) begin
            state   <= tx_data;
            bit_idx <= '0;
          end
        end
        tx_data: begin
          if (bit_end) begin
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state <= tx_stop;
            end
          end
        end
        tx_stop: begin
          // next byte follows straight after the stop bit
          if (bit_end) begin
            if (byte_idx == LAST_BYTE) begin
              state    <= tx_idle;
              byte_idx <= '0;
            end else begin
              state    <= tx_start;
              byte_idx <= byte_idx + 1'b1;
            end
          end
        end
        default: state <= tx_idle;
      endcase
    end
  end

  // lsb first, line idles high
  always_comb begin
    case (state)
      tx_start: tx_line = 1'b0;
      tx_data:  tx_line = cur_byte[bit_idx];
      default:  tx_line = 1'b1;
    endcase
  end

  assign tx_de   = (state != tx_idle);
  assign tx_busy = tx_de | cmd_vld;

endmodule

`default_nettype wire

// ==== hdl/cspi_rx.sv ====
`default_nettype none

module cspi_rx (
  input  logic                       clk_sys,
  input  logic                       rst_n,
  input  logic                       spi_csn,
  input  logic                       spi_sck,
  input  logic                       spi_mosi,
  output logic [link_pkg::CMD_W-1:0] cmd_word,
  output logic                       cmd_vld
);
  import link_pkg::*;

  localparam int CNT_W = $clog2(CMD_W + 2);
  localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(CMD_W + 1);

  // two sync flops per pin, the extra flop is for edge detect
  logic [1:0]       csn_sync;
  logic [1:0]       sck_sync;
  logic [1:0]       mosi_sync;
  logic             csn_d;
  logic             sck_d;
  logic [CNT_W-1:0] bit_cnt;
  logic [CMD_W-1:0] shift_q;
  logic             csn_rise;
  logic             csn_fall;
  logic             sck_rise;

  always_ff @(posedge clk_sys or negedge rst_n) begin
    if (!rst_n) begin
      csn_sync  <= 2'b11;
      sck_sync  <= 2'b00;
      mosi_sync <= 2'b00;
      csn_d     <= 1'b1;
      sck_d     <= 1'b0;
    end else begin
      csn_sync  <= {csn_sync[0], spi_csn};
      sck_sync  <= {sck_sync[0], spi_sck};
      mosi_sync <= {mosi_sync[0], spi_mosi};
      csn_d     <= csn_sync[1];
      sck_d     <= sck_sync[1];
    end
  end

  assign csn_rise = csn_sync[1] & ~csn_d;
  assign csn_fall = ~csn_sync[1] & csn_d;
  // mode 0, only count edges inside the transfer
  assign sck_rise = sck_sync[1] & ~sck_d & ~csn_sync[1];

  // bit count saturates one above a full word, so long transfers fail too
  always_ff @(posedge clk_sys or negedge rst_n) begin
    if (!rst_n) begin
      bit_cnt <= '0;
      cmd_vld <= 1'b0;
    end else begin
      cmd_vld <= csn_rise && (bit_cnt == CNT_W'(CMD_W));
      if (csn_fall) begin
        bit_cnt <= '0;
      end else if (sck_rise && bit_cnt != CNT_MAX) begin
        bit_cnt <= bit_cnt + 1'b1;
      end
    end
  end

  // msb arrives first
  always_ff @(posedge clk_sys) begin
    if (sck_rise) begin
      shift_q <= {shift_q[CMD_W-2:0], mosi_sync[1]};
    end
  end

  assign cmd_word = shift_q;

endmodule

`default_nettype wire

// ==== hdl/link_pkg.sv ====
`default_nettype none

package link_pkg;

  // one command word from the control processor
  // dev_id, mod_id, cmd_addr, cmd_data, msb first
  parameter int CMD_W = 32;

  // start-of-frame marker on the line
  parameter logic [7:0] SYNC_BYTE = 8'hA5;

  // sync, four payload bytes, checksum
  parameter int FRAME_BYTES = 6;

  // master line framer
  typedef enum logic [1:0] {
    tx_idle,
    tx_start,
    tx_data,
    tx_stop
  } tx_state_t;

  // slave line deframer
  typedef enum logic [1:0] {
    rx_idle,
    rx_start,
    rx_data,
    rx_stop
  } rx_state_t;

endpackage

`default_nettype wire
